/* rtl/app_datapath_defs.svh */
`ifndef APP_DATAPATH_DEFS_SVH
`define APP_DATAPATH_DEFS_SVH

// ==============================
// stream geometry
// ==============================

// bytes per beat, data is this times 8
`define APP_DATA_BYTES 8
// tid / tdest width, four ports
`define APP_PORT_W 2
`define APP_NUM_PORTS 4
// rss hash input width
`define APP_ENTROPY_W 12
// truncation length width in bytes
`define APP_LEN_W 16

// ==============================
// register port
// ==============================

`define APP_CFG_ADDR_W 4
`define APP_CFG_DATA_W 32

// word addresses
`define APP_REG_TID_OVR 4'd0
// remap entries at base + source port
`define APP_REG_TDEST_REMAP_BASE 4'd1
`define APP_REG_TRUNC 4'd5
`define APP_REG_RSS 4'd6

`endif

/* rtl/axis_beat_pkg.sv */
`include "app_datapath_defs.svh"

package axis_beat_pkg;

    // ==============================
    // scalar types
    // ==============================

    // source or destination port
    typedef logic [`APP_PORT_W-1:0] port_t;

    // rss hash input carried to the host
    typedef logic [`APP_ENTROPY_W-1:0] entropy_t;

    // valid low-order bytes in a beat, 1 to 8
    typedef logic [$clog2(`APP_DATA_BYTES + 1)-1:0] byte_cnt_t;

    // ==============================
    // one stream beat
    // ==============================

    typedef struct packed {
        // payload, byte 0 in the low bits
        logic [`APP_DATA_BYTES*8-1:0] data;
        // byte count, not a strobe mask
        byte_cnt_t                    keep;
        // end of packet
        logic                         last;
        port_t                        tid;
        port_t                        tdest;
        // receive side scaling metadata
        logic                         rss_enable;
        entropy_t                     rss_entropy;
    } axis_beat_t;

endpackage

/* rtl/proc_cfg_pkg.sv */
`include "app_datapath_defs.svh"

package proc_cfg_pkg;

    import axis_beat_pkg::*;

    // packet length in bytes
    typedef logic [`APP_LEN_W-1:0] pkt_len_t;

    // tid relabel, enable sits in the msb
    typedef struct packed {
        logic  enable;
        port_t value;
    } tid_ovr_cfg_t;

    // egress truncation, both enables must be set
    typedef struct packed {
        logic     enable;
        logic     trunc_enable;
        pkt_len_t trunc_length;
    } trunc_cfg_t;

    // ==============================
    // full datapath config
    // ==============================

    typedef struct packed {
        tid_ovr_cfg_t                   tid_ovr;
        // tdest indexed by tid
        port_t [`APP_NUM_PORTS-1:0]     remap;
        trunc_cfg_t                     trunc;
        logic                           rss_enable;
    } proc_cfg_t;

endpackage

/* rtl/proc_cfg_regs.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module proc_cfg_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_wr,
    input  logic [`APP_CFG_ADDR_W-1:0]   cfg_addr,
    input  logic [`APP_CFG_DATA_W-1:0]   cfg_wdata,
    output proc_cfg_pkg::proc_cfg_t      cfg
);

    import axis_beat_pkg::*;
    import proc_cfg_pkg::*;

    // offset into the remap window
    logic [`APP_CFG_ADDR_W-1:0] remap_off;
    logic                       remap_hit;
    port_t                      remap_idx;

    assign remap_off = cfg_addr - `APP_REG_TDEST_REMAP_BASE;
    // window is base .. base+3
    assign remap_hit = (cfg_addr >= `APP_REG_TDEST_REMAP_BASE) &&
                       (remap_off < `APP_NUM_PORTS);
    assign remap_idx = remap_off[`APP_PORT_W-1:0];

    // ==============================
    // write decode
    // ==============================

    // field layouts in wdata
    // tid_ovr   bit 2 enable, bits 1:0 value
    // remap     bits 1:0 tdest
    // trunc     bit 17 enable, bit 16 trunc_enable, bits 15:0 length
    // rss       bit 0 enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.tid_ovr    <= '0;
            cfg.trunc      <= '0;
            cfg.rss_enable <= 1'b0;
            // identity map, port i goes to i
            for (int i = 0; i < `APP_NUM_PORTS; i++) begin
                cfg.remap[i] <= port_t'(i);
            end
        end else if (cfg_wr) begin
            if (cfg_addr == `APP_REG_TID_OVR) begin
                cfg.tid_ovr <= tid_ovr_cfg_t'(cfg_wdata[$bits(tid_ovr_cfg_t)-1:0]);
            end else if (remap_hit) begin
                cfg.remap[remap_idx] <= cfg_wdata[`APP_PORT_W-1:0];
            end else if (cfg_addr == `APP_REG_TRUNC) begin
                cfg.trunc <= trunc_cfg_t'(cfg_wdata[$bits(trunc_cfg_t)-1:0]);
            end else if (cfg_addr == `APP_REG_RSS) begin
                cfg.rss_enable <= cfg_wdata[0];
            end
            // anything else dropped silently
        end
    end

endmodule

/* rtl/igr_tid_tagger.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module igr_tid_tagger (
    input  logic                          clk,
    input  logic                          rst_n,
    input  proc_cfg_pkg::tid_ovr_cfg_t    cfg_tid_ovr,
    input  logic                          cfg_rss_enable,
    input  logic                          in_valid,
    input  axis_beat_pkg::axis_beat_t     in_beat,
    output logic                          out_valid,
    output axis_beat_pkg::axis_beat_t     out_beat
);

    import axis_beat_pkg::*;
    import proc_cfg_pkg::*;

    // override latched at sop
    tid_ovr_cfg_t ovr_held;
    tid_ovr_cfg_t ovr_sel;
    // set between first and last beat
    logic         mid_pkt;
    port_t        tid_final;
    axis_beat_t   beat_tagged;

    // first beat takes live config, the rest reuse the held copy
    assign ovr_sel   = mid_pkt ? ovr_held : cfg_tid_ovr;
    assign tid_final = ovr_sel.enable ? ovr_sel.value : in_beat.tid;

    always_comb begin
        beat_tagged             = in_beat;
        beat_tagged.tid         = tid_final;
        beat_tagged.rss_enable  = cfg_rss_enable;
        // entropy is just the final tid, zero extended
        beat_tagged.rss_entropy = entropy_t'(tid_final);
    end

    // ==============================
    // packet tracking
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            mid_pkt   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                mid_pkt <= !in_beat.last;
            end
        end
    end

    // payload and held override
    always_ff @(posedge clk) begin
        if (in_valid && !mid_pkt) begin
            ovr_held <= cfg_tid_ovr;
        end
        if (in_valid) begin
            out_beat <= beat_tagged;
        end
    end

endmodule

/* rtl/tdest_remap.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module tdest_remap (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  axis_beat_pkg::port_t [`APP_NUM_PORTS-1:0] remap,
    input  logic                                      in_valid,
    input  axis_beat_pkg::axis_beat_t                 in_beat,
    output logic                                      out_valid,
    output axis_beat_pkg::axis_beat_t                 out_beat
);

    import axis_beat_pkg::*;

    axis_beat_t beat_remapped;
    port_t      tdest_new;

    // ==============================
    // table lookup
    // ==============================

    // indexed by the tid after relabel
    assign tdest_new = remap[in_beat.tid];

    always_comb begin
        beat_remapped       = in_beat;
        beat_remapped.tdest = tdest_new;
    end

    // valid pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // beat register, only loads on a real beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_beat <= beat_remapped;
        end
    end

endmodule

/* rtl/egr_pkt_trunc.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module egr_pkt_trunc (
    input  logic                          clk,
    input  logic                          rst_n,
    input  proc_cfg_pkg::trunc_cfg_t      cfg_trunc,
    input  logic                          in_valid,
    input  axis_beat_pkg::axis_beat_t     in_beat,
    output logic                          out_valid,
    output axis_beat_pkg::axis_beat_t     out_beat
);

    import axis_beat_pkg::*;
    import proc_cfg_pkg::*;

    // config held for the whole packet
    trunc_cfg_t trunc_held;
    trunc_cfg_t trunc_sel;
    logic       trunc_on;
    // between first and last input beat
    logic       mid_pkt;
    // cut already done, swallow until input last
    logic       dropping;
    // bytes passed so far in this packet
    pkt_len_t   byte_cnt;
    pkt_len_t   cnt_next;
    logic       cut_here;
    axis_beat_t beat_cut;

    // ==============================
    // cut decision
    // ==============================

    assign trunc_sel = mid_pkt ? trunc_held : cfg_trunc;
    assign trunc_on  = trunc_sel.enable && trunc_sel.trunc_enable;
    assign cnt_next  = byte_cnt + pkt_len_t'(in_beat.keep);

    // this beat reaches or crosses the limit
    assign cut_here = trunc_on && !dropping &&
                      (cnt_next >= trunc_sel.trunc_length);

    always_comb begin
        beat_cut = in_beat;
        if (cut_here) begin
            // remainder fits a beat since byte_cnt is still below the limit
            beat_cut.keep = byte_cnt_t'(trunc_sel.trunc_length - byte_cnt);
            beat_cut.last = 1'b1;
        end
    end

    // ==============================
    // counter and drop state
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            mid_pkt   <= 1'b0;
            dropping  <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            // dropped slots stay empty
            out_valid <= in_valid && !dropping;
            if (in_valid) begin
                mid_pkt <= !in_beat.last;
                if (in_beat.last) begin
                    // next packet starts clean
                    byte_cnt <= '0;
                    dropping <= 1'b0;
                end else begin
                    byte_cnt <= cnt_next;
                    if (cut_here) begin
                        dropping <= 1'b1;
                    end
                end
            end
        end
    end

    // sample config on sop, register kept beats
    always_ff @(posedge clk) begin
        if (in_valid && !mid_pkt) begin
            trunc_held <= cfg_trunc;
        end
        if (in_valid && !dropping) begin
            out_beat <= beat_cut;
        end
    end

endmodule

/* rtl/app_datapath.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module app_datapath (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_wr,
    input  logic [`APP_CFG_ADDR_W-1:0]    cfg_addr,
    input  logic [`APP_CFG_DATA_W-1:0]    cfg_wdata,
    input  logic                          in_valid,
    input  axis_beat_pkg::axis_beat_t     in_beat,
    output logic                          out_valid,
    output axis_beat_pkg::axis_beat_t     out_beat
);

    import axis_beat_pkg::*;
    import proc_cfg_pkg::*;

    proc_cfg_t  cfg;

    // stage 1 to 2
    logic       tag_valid;
    axis_beat_t tag_beat;
    // stage 2 to 3
    logic       remap_valid;
    axis_beat_t remap_beat;

    // ==============================
    // config registers
    // ==============================

    proc_cfg_regs proc_cfg_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    // ==============================
    // three stage pipe
    // ==============================

    // relabel and rss
    igr_tid_tagger igr_tid_tagger_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_tid_ovr    (cfg.tid_ovr),
        .cfg_rss_enable (cfg.rss_enable),
        .in_valid       (in_valid),
        .in_beat        (in_beat),
        .out_valid      (tag_valid),
        .out_beat       (tag_beat)
    );

    // tdest lookup
    tdest_remap tdest_remap_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .remap     (cfg.remap),
        .in_valid  (tag_valid),
        .in_beat   (tag_beat),
        .out_valid (remap_valid),
        .out_beat  (remap_beat)
    );

    // egress cut
    egr_pkt_trunc egr_pkt_trunc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_trunc (cfg.trunc),
        .in_valid  (remap_valid),
        .in_beat   (remap_beat),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

endmodule

/* test/app_datapath_assertions.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module app_datapath_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          cfg_wr,
    input logic [`APP_CFG_ADDR_W-1:0]    cfg_addr,
    input logic [`APP_CFG_DATA_W-1:0]    cfg_wdata,
    input logic                          in_valid,
    input axis_beat_pkg::axis_beat_t     in_beat,
    input logic                          out_valid,
    input axis_beat_pkg::axis_beat_t     out_beat
);

    import axis_beat_pkg::*;
    import proc_cfg_pkg::*;

    // read by the testbench after each test
    int         fail_count = 0;

    // register file as seen on the write port
    proc_cfg_t  shadow;
    // settings frozen at the first beat of a packet
    proc_cfg_t  pkt_cfg;
    proc_cfg_t  cur_cfg;
    logic       mid_pkt;
    int         bytes_seen;
    int         lim;
    logic       now_keep;
    axis_beat_t now_beat;
    // one expected slot per pipe stage
    logic [2:0] exp_valid;
    axis_beat_t exp_beat [3];

    // ==============================
    // reference model
    // ==============================

    always_comb begin
        cur_cfg              = mid_pkt ? pkt_cfg : shadow;
        lim                  = int'(cur_cfg.trunc.trunc_length);
        now_beat             = in_beat;
        now_beat.tid         = cur_cfg.tid_ovr.enable ? cur_cfg.tid_ovr.value : in_beat.tid;
        now_beat.tdest       = cur_cfg.remap[now_beat.tid];
        now_beat.rss_enable  = cur_cfg.rss_enable;
        now_beat.rss_entropy = entropy_t'(now_beat.tid);
        now_keep             = 1'b1;
        if (cur_cfg.trunc.enable && cur_cfg.trunc.trunc_enable) begin
            if (bytes_seen >= lim) begin
                // limit already reached, beat vanishes
                now_keep = 1'b0;
            end else if (bytes_seen + int'(in_beat.keep) >= lim) begin
                now_beat.keep = byte_cnt_t'(lim - bytes_seen);
                now_beat.last = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow     <= '0;
            mid_pkt    <= 1'b0;
            bytes_seen <= 0;
            exp_valid  <= '0;
            for (int i = 0; i < `APP_NUM_PORTS; i++) begin
                shadow.remap[i] <= port_t'(i);
            end
        end else begin
            if (cfg_wr) begin
                if (cfg_addr == `APP_REG_TID_OVR) begin
                    shadow.tid_ovr <= cfg_wdata[2:0];
                end else if (cfg_addr >= `APP_REG_TDEST_REMAP_BASE &&
                             cfg_addr < `APP_REG_TDEST_REMAP_BASE + `APP_NUM_PORTS) begin
                    shadow.remap[port_t'(cfg_addr - `APP_REG_TDEST_REMAP_BASE)] <=
                        cfg_wdata[`APP_PORT_W-1:0];
                end else if (cfg_addr == `APP_REG_TRUNC) begin
                    shadow.trunc <= cfg_wdata[17:0];
                end else if (cfg_addr == `APP_REG_RSS) begin
                    shadow.rss_enable <= cfg_wdata[0];
                end
            end
            if (in_valid) begin
                if (!mid_pkt) begin
                    pkt_cfg <= shadow;
                end
                mid_pkt    <= !in_beat.last;
                bytes_seen <= in_beat.last ? 0 : bytes_seen + int'(in_beat.keep);
            end
            exp_valid   <= {exp_valid[1:0], in_valid && now_keep};
            exp_beat[0] <= now_beat;
            exp_beat[1] <= exp_beat[0];
            exp_beat[2] <= exp_beat[1];
        end
    end

    // ==============================
    // checks
    // ==============================

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid went high right after a reset cycle");
            fail_count++;
        end

    // covers latency, dropped slots and gaps
    a_valid_slot: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == exp_valid[2])
        else begin
            $error("[FAIL] %0t out_valid %0b expected %0b", $time, out_valid, exp_valid[2]);
            fail_count++;
        end

    a_tdest: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_beat.tdest == exp_beat[2].tdest)
        else begin
            $error("[FAIL] %0t tdest %0d expected %0d", $time,
                   out_beat.tdest, exp_beat[2].tdest);
            fail_count++;
        end

    a_tid_rss: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_beat.tid == exp_beat[2].tid &&
                      out_beat.rss_enable == exp_beat[2].rss_enable &&
                      out_beat.rss_entropy == exp_beat[2].rss_entropy)
        else begin
            $error("[FAIL] %0t tid or rss metadata wrong, tid %0d expected %0d",
                   $time, out_beat.tid, exp_beat[2].tid);
            fail_count++;
        end

    a_keep_last: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_beat.keep == exp_beat[2].keep &&
                      out_beat.last == exp_beat[2].last)
        else begin
            $error("[FAIL] %0t keep %0d last %0b expected keep %0d last %0b", $time,
                   out_beat.keep, out_beat.last, exp_beat[2].keep, exp_beat[2].last);
            fail_count++;
        end

    a_payload: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_beat.data == exp_beat[2].data)
        else begin
            $error("[FAIL] %0t payload %h expected %h", $time,
                   out_beat.data, exp_beat[2].data);
            fail_count++;
        end

endmodule

bind app_datapath app_datapath_checker checker_i (.*);

/* test/app_datapath_tb.sv */
`timescale 1ns/1ps
`include "app_datapath_defs.svh"

module app_datapath_tb;

    import axis_beat_pkg::*;

    // six tests of up to 800 cycles plus margin
    localparam int MAX_CYCLES = 6000;

    logic                       clk;
    logic                       rst_n;
    logic                       cfg_wr;
    logic [`APP_CFG_ADDR_W-1:0] cfg_addr;
    logic [`APP_CFG_DATA_W-1:0] cfg_wdata;
    logic                       in_valid;
    axis_beat_t                 in_beat;
    logic                       out_valid;
    axis_beat_t                 out_beat;

    int cycle_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int fails_seen   = 0;

    app_datapath app_datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==============================
    // run limit
    // ==============================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles, test sequence did not complete",
                     cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic int pick_in_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // one-cycle strobe that lands once the previous packet has cleared the remap stage
    task automatic write_reg(input logic [`APP_CFG_ADDR_W-1:0] addr, input logic [31:0] data);
        idle_cycles(1);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    // stream fields are random so that stage 1 has to overwrite rss
    task automatic send_packet(input int n_beats, input port_t tid);
        axis_beat_t beat;
        for (int b = 0; b < n_beats; b++) begin
            beat.data        = {$urandom, $urandom};
            beat.last        = (b == n_beats - 1);
            beat.keep        = beat.last ? byte_cnt_t'(pick_in_range(1, 8)) : byte_cnt_t'(8);
            beat.tid         = tid;
            beat.tdest       = port_t'($urandom);
            beat.rss_enable  = 1'($urandom);
            beat.rss_entropy = entropy_t'($urandom);
            @(posedge clk);
            in_valid <= 1'b1;
            in_beat  <= beat;
            // occasional bubble inside the packet
            if (!beat.last && pick_in_range(0, 3) == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
    endtask

    // drain covers the three stage latency and the assertion region
    task automatic finish_test(input string name);
        int now_fails;
        idle_cycles(5);
        now_fails = app_datapath_i.checker_i.fail_count;
        tests_run++;
        if (now_fails != fails_seen) begin
            tests_failed++;
            $display("[FAIL] %0t %s: %0d assertion failures", $time, name,
                     now_fails - fails_seen);
        end else begin
            $display("[PASS] %s", name);
        end
        fails_seen = now_fails;
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        void'($urandom(32'h2e5afd9b));
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        in_valid  = 1'b0;
        in_beat   = '0;
        // offer beats while reset is held
        @(posedge clk);
        in_valid <= 1'b1;
        repeat (9) @(posedge clk);
        rst_n    <= 1'b1;
        in_valid <= 1'b0;
        finish_test("reset");

        // config still at reset values
        repeat (4) send_packet(pick_in_range(1, 40), port_t'($urandom));
        finish_test("loopback");

        for (int r = 1; r <= 4; r++) begin
            for (int i = 0; i < `APP_NUM_PORTS; i++) begin
                write_reg(`APP_CFG_ADDR_W'(`APP_REG_TDEST_REMAP_BASE + i), (i + r) % 4);
            end
            for (int t = 0; t < `APP_NUM_PORTS; t++) begin
                send_packet(pick_in_range(1, 40), port_t'(t));
            end
        end
        finish_test("tdest_remap");

        write_reg(`APP_REG_RSS, 32'd1);
        write_reg(`APP_REG_TID_OVR, {29'd0, 1'b1, 2'd2});
        repeat (3) send_packet(pick_in_range(1, 40), port_t'($urandom));
        write_reg(`APP_REG_TID_OVR, {29'd0, 1'b1, 2'd3});
        repeat (3) send_packet(pick_in_range(1, 40), port_t'($urandom));
        write_reg(`APP_REG_TID_OVR, 32'd0);
        finish_test("rss_tid_relabel");

        // 40 beats always cross a limit of at most 300 bytes
        write_reg(`APP_REG_TRUNC, {14'd0, 2'b11, 16'(pick_in_range(65, 300))});
        send_packet(40, port_t'($urandom));
        send_packet(pick_in_range(1, 40), port_t'($urandom));
        // fresh limit for each pair of back to back packets
        repeat (3) begin
            write_reg(`APP_REG_TRUNC, {14'd0, 2'b11, 16'(pick_in_range(65, 500))});
            repeat (2) send_packet(pick_in_range(1, 40), port_t'($urandom));
        end
        finish_test("egress_trunc");

        for (int p = 0; p < 6; p++) begin
            write_reg(`APP_REG_TRUNC,
                      {14'd0, 1'(p % 2), 1'b1, 16'(pick_in_range(65, 500))});
            write_reg(`APP_REG_TID_OVR, {29'd0, 1'(p / 2 % 2), 2'($urandom)});
            send_packet(pick_in_range(1, 40), port_t'($urandom));
        end
        finish_test("cfg_toggle");

        $display("tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, fails_seen);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+rtl
rtl/axis_beat_pkg.sv
rtl/proc_cfg_pkg.sv
rtl/proc_cfg_regs.sv
rtl/igr_tid_tagger.sv
rtl/tdest_remap.sv
rtl/egr_pkt_trunc.sv
rtl/app_datapath.sv
test/app_datapath_assertions.sv
test/app_datapath_tb.sv

/* Bender.yml */
package:
  name: app_datapath

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axis_beat_pkg.sv
      - rtl/proc_cfg_pkg.sv
      - rtl/proc_cfg_regs.sv
      - rtl/igr_tid_tagger.sv
      - rtl/tdest_remap.sv
      - rtl/egr_pkt_trunc.sv
      - rtl/app_datapath.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/app_datapath_assertions.sv
      - test/app_datapath_tb.sv
